/* hw/core_settings.svh */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// ==================================================
// Core dimensions
// ==================================================

`define XLEN      32  // Data path and pc width.
`define REG_COUNT 16  // RV32E register file size.
`define REG_IDX_W 4   // Index width for REG_COUNT registers.

`endif

/* hw/rv_isa_pkg.sv */
package rv_isa_pkg;

    // ==================================================
    // Encodings taken from the instruction word
    // ==================================================

    typedef enum logic [6:0] {
        op_reg    = 7'b0110011,
        op_imm    = 7'b0010011,
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011
    } opcode_e;

    typedef enum logic [2:0] {
        f3_add  = 3'b000,  // Also sub when funct7 selects the alternate op.
        f3_sll  = 3'b001,
        f3_slt  = 3'b010,
        f3_sltu = 3'b011,
        f3_xor  = 3'b100,
        f3_sr   = 3'b101,  // srl or sra.
        f3_or   = 3'b110,
        f3_and  = 3'b111
    } funct3_e;

    // ==================================================
    // Internal control codes
    // ==================================================

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
        alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
    } alu_op_e;

    typedef enum logic [2:0] {
        br_none, br_eq, br_ne, br_lt, br_ge, br_ltu, br_geu, br_always
    } branch_e;

endpackage

/* hw/core_bus_pkg.sv */
`include "core_settings.svh"

package core_bus_pkg;

    // ==================================================
    // Fetch to decode
    // ==================================================

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] inst;
    } fetch_t;

    // ==================================================
    // Decode to execute
    // ==================================================

    typedef struct packed {
        logic [`XLEN-1:0]      pc;
        logic [`XLEN-1:0]      src1;
        logic [`XLEN-1:0]      src2;
        logic [`XLEN-1:0]      imm;
        logic [`REG_IDX_W-1:0] rd;
        rv_isa_pkg::alu_op_e   alu_op;
        rv_isa_pkg::branch_e   branch;
        logic                  src1_is_pc;
        logic                  src2_is_imm;
        logic                  link;     // Writes pc+4 instead of the ALU result.
        logic                  reg_we;
        logic                  illegal;
    } decoded_t;

    // ==================================================
    // Execute to result, and the retire port
    // ==================================================

    typedef struct packed {
        logic [`XLEN-1:0]      pc;
        logic [`XLEN-1:0]      result;
        logic [`REG_IDX_W-1:0] rd;
        logic                  reg_we;
        logic                  illegal;
    } exec_t;

    typedef struct packed {
        logic [`XLEN-1:0]      pc;
        logic [`XLEN-1:0]      result;
        logic [`REG_IDX_W-1:0] rd;
        logic                  reg_we;
        logic                  illegal;
    } retire_t;

endpackage

/* hw/decode_stage.sv */
`include "core_settings.svh"

module decode_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_valid,
    input  core_bus_pkg::fetch_t   in_fetch,
    output logic                   in_ready,
    input  logic                   out_ready,
    output logic                   advance,
    input  logic                   redirect_valid,
    input  logic                   exe_valid,
    input  core_bus_pkg::exec_t    exe,
    output logic [`REG_IDX_W-1:0]  rs1_idx,
    output logic [`REG_IDX_W-1:0]  rs2_idx,
    input  logic [`XLEN-1:0]       rs1_data,
    input  logic [`XLEN-1:0]       rs2_data,
    output logic                   dec_valid,
    output core_bus_pkg::decoded_t dec
);

    logic [6:0]             opcode;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    logic [4:0]             rd_f;
    logic [4:0]             rs1_f;
    logic [4:0]             rs2_f;
    logic [`XLEN-1:0]       imm_i;
    logic [`XLEN-1:0]       imm_b;
    logic [`XLEN-1:0]       imm_u;
    logic [`XLEN-1:0]       imm_j;
    logic                   fwd_rs1;
    logic                   fwd_rs2;
    logic [`XLEN-1:0]       src1_fwd;
    logic [`XLEN-1:0]       src2_fwd;
    logic                   known;
    logic                   uses_rs1;
    logic                   uses_rs2;
    logic                   uses_rd;
    core_bus_pkg::decoded_t dec_next;

    function automatic rv_isa_pkg::alu_op_e alu_from_funct3(input logic [2:0] f3,
                                                            input logic alt);
        case (f3)
            rv_isa_pkg::f3_add:  return alt ? rv_isa_pkg::alu_sub : rv_isa_pkg::alu_add;
            rv_isa_pkg::f3_sll:  return rv_isa_pkg::alu_sll;
            rv_isa_pkg::f3_slt:  return rv_isa_pkg::alu_slt;
            rv_isa_pkg::f3_sltu: return rv_isa_pkg::alu_sltu;
            rv_isa_pkg::f3_xor:  return rv_isa_pkg::alu_xor;
            rv_isa_pkg::f3_sr:   return alt ? rv_isa_pkg::alu_sra : rv_isa_pkg::alu_srl;
            rv_isa_pkg::f3_or:   return rv_isa_pkg::alu_or;
            default:             return rv_isa_pkg::alu_and;
        endcase
    endfunction

    assign advance  = out_ready;
    assign in_ready = out_ready;  // Ready passes straight back from the retire port.

    assign opcode = in_fetch.inst[6:0];
    assign funct3 = in_fetch.inst[14:12];
    assign funct7 = in_fetch.inst[31:25];
    assign rd_f   = in_fetch.inst[11:7];
    assign rs1_f  = in_fetch.inst[19:15];
    assign rs2_f  = in_fetch.inst[24:20];

    assign imm_i = {{20{in_fetch.inst[31]}}, in_fetch.inst[31:20]};
    assign imm_b = {{20{in_fetch.inst[31]}}, in_fetch.inst[7], in_fetch.inst[30:25],
                    in_fetch.inst[11:8], 1'b0};
    assign imm_u = {in_fetch.inst[31:12], 12'b0};
    assign imm_j = {{12{in_fetch.inst[31]}}, in_fetch.inst[19:12], in_fetch.inst[20],
                    in_fetch.inst[30:21], 1'b0};

    // ==================================================
    // Operand read with bypass from execute
    // ==================================================

    assign rs1_idx = rs1_f[`REG_IDX_W-1:0];
    assign rs2_idx = rs2_f[`REG_IDX_W-1:0];

    // The executing instruction commits on the same edge that captures this one.
    assign fwd_rs1  = exe_valid && exe.reg_we && (exe.rd == rs1_idx) && (rs1_idx != '0);
    assign fwd_rs2  = exe_valid && exe.reg_we && (exe.rd == rs2_idx) && (rs2_idx != '0);
    assign src1_fwd = fwd_rs1 ? exe.result : rs1_data;
    assign src2_fwd = fwd_rs2 ? exe.result : rs2_data;

    always_comb begin
        dec_next        = '0;
        dec_next.pc     = in_fetch.pc;
        dec_next.src1   = src1_fwd;
        dec_next.src2   = src2_fwd;
        dec_next.rd     = rd_f[`REG_IDX_W-1:0];
        dec_next.alu_op = rv_isa_pkg::alu_add;
        dec_next.branch = rv_isa_pkg::br_none;
        known           = 1'b1;
        uses_rs1        = 1'b0;
        uses_rs2        = 1'b0;
        uses_rd         = 1'b0;
        case (opcode)
            rv_isa_pkg::op_reg: begin
                uses_rs1        = 1'b1;
                uses_rs2        = 1'b1;
                uses_rd         = 1'b1;
                dec_next.alu_op = alu_from_funct3(funct3, funct7[5]);
                known = (funct7 == 7'h00) || ((funct7 == 7'h20) &&
                        (funct3 == rv_isa_pkg::f3_add || funct3 == rv_isa_pkg::f3_sr));
            end
            rv_isa_pkg::op_imm: begin
                uses_rs1             = 1'b1;
                uses_rd              = 1'b1;
                dec_next.src2_is_imm = 1'b1;
                dec_next.imm         = imm_i;
                dec_next.alu_op      = alu_from_funct3(funct3,
                                           (funct3 == rv_isa_pkg::f3_sr) && funct7[5]);
                if (funct3 == rv_isa_pkg::f3_sll) begin
                    known = (funct7 == 7'h00);
                end else if (funct3 == rv_isa_pkg::f3_sr) begin
                    known = (funct7 == 7'h00) || (funct7 == 7'h20);
                end
            end
            rv_isa_pkg::op_lui: begin
                uses_rd              = 1'b1;
                dec_next.src2_is_imm = 1'b1;
                dec_next.imm         = imm_u;
                dec_next.alu_op      = rv_isa_pkg::alu_pass_b;
            end
            rv_isa_pkg::op_auipc: begin
                uses_rd              = 1'b1;
                dec_next.src1_is_pc  = 1'b1;
                dec_next.src2_is_imm = 1'b1;
                dec_next.imm         = imm_u;
            end
            rv_isa_pkg::op_jal: begin
                uses_rd              = 1'b1;
                dec_next.src1_is_pc  = 1'b1;
                dec_next.src2_is_imm = 1'b1;
                dec_next.imm         = imm_j;
                dec_next.link        = 1'b1;
                dec_next.branch      = rv_isa_pkg::br_always;
            end
            rv_isa_pkg::op_jalr: begin
                uses_rs1             = 1'b1;
                uses_rd              = 1'b1;
                dec_next.src2_is_imm = 1'b1;
                dec_next.imm         = imm_i;
                dec_next.link        = 1'b1;
                dec_next.branch      = rv_isa_pkg::br_always;
                known                = (funct3 == 3'b000);
            end
            rv_isa_pkg::op_branch: begin
                uses_rs1             = 1'b1;
                uses_rs2             = 1'b1;
                dec_next.src1_is_pc  = 1'b1;  // The ALU forms pc plus the offset.
                dec_next.src2_is_imm = 1'b1;
                dec_next.imm         = imm_b;
                case (funct3)
                    3'b000:  dec_next.branch = rv_isa_pkg::br_eq;
                    3'b001:  dec_next.branch = rv_isa_pkg::br_ne;
                    3'b100:  dec_next.branch = rv_isa_pkg::br_lt;
                    3'b101:  dec_next.branch = rv_isa_pkg::br_ge;
                    3'b110:  dec_next.branch = rv_isa_pkg::br_ltu;
                    3'b111:  dec_next.branch = rv_isa_pkg::br_geu;
                    default: known = 1'b0;
                endcase
            end
            default: known = 1'b0;
        endcase
        dec_next.reg_we  = uses_rd;
        // RV32E has no registers above x15, so a set high index bit is illegal.
        dec_next.illegal = !known || (uses_rs1 && (|rs1_f[4:`REG_IDX_W])) ||
                           (uses_rs2 && (|rs2_f[4:`REG_IDX_W])) ||
                           (uses_rd && (|rd_f[4:`REG_IDX_W]));
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dec_valid <= 1'b0;
            dec       <= '0;
        end else if (advance) begin
            dec_valid <= in_valid && !redirect_valid;  // Wrong-path fetch is dropped.
            dec       <= dec_next;
        end
    end

endmodule

/* hw/execute_stage.sv */
`include "core_settings.svh"

module execute_stage (
    input  logic                   dec_valid,
    input  core_bus_pkg::decoded_t dec,
    input  logic                   advance,
    output logic                   exe_valid,
    output core_bus_pkg::exec_t    exe,
    output logic                   redirect_valid,
    output logic [`XLEN-1:0]       redirect_pc
);

    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [4:0]       shamt;
    logic [`XLEN-1:0] alu_res;
    logic             lt_s;
    logic             lt_u;
    logic             taken;

    assign op_a  = dec.src1_is_pc ? dec.pc : dec.src1;
    assign op_b  = dec.src2_is_imm ? dec.imm : dec.src2;
    assign shamt = op_b[4:0];
    assign lt_s  = $signed(op_a) < $signed(op_b);
    assign lt_u  = op_a < op_b;

    // ==================================================
    // ALU
    // ==================================================

    always_comb begin
        case (dec.alu_op)
            rv_isa_pkg::alu_sub:    alu_res = op_a - op_b;
            rv_isa_pkg::alu_sll:    alu_res = op_a << shamt;
            rv_isa_pkg::alu_slt:    alu_res = {{(`XLEN-1){1'b0}}, lt_s};
            rv_isa_pkg::alu_sltu:   alu_res = {{(`XLEN-1){1'b0}}, lt_u};
            rv_isa_pkg::alu_xor:    alu_res = op_a ^ op_b;
            rv_isa_pkg::alu_srl:    alu_res = op_a >> shamt;
            rv_isa_pkg::alu_sra:    alu_res = $signed(op_a) >>> shamt;
            rv_isa_pkg::alu_or:     alu_res = op_a | op_b;
            rv_isa_pkg::alu_and:    alu_res = op_a & op_b;
            rv_isa_pkg::alu_pass_b: alu_res = op_b;
            default:                alu_res = op_a + op_b;
        endcase
    end

    // ==================================================
    // Branch resolution
    // ==================================================

    // The ALU holds the target, so the condition compares the raw register operands.
    always_comb begin
        case (dec.branch)
            rv_isa_pkg::br_eq:     taken = (dec.src1 == dec.src2);
            rv_isa_pkg::br_ne:     taken = (dec.src1 != dec.src2);
            rv_isa_pkg::br_lt:     taken = $signed(dec.src1) < $signed(dec.src2);
            rv_isa_pkg::br_ge:     taken = $signed(dec.src1) >= $signed(dec.src2);
            rv_isa_pkg::br_ltu:    taken = dec.src1 < dec.src2;
            rv_isa_pkg::br_geu:    taken = dec.src1 >= dec.src2;
            rv_isa_pkg::br_always: taken = 1'b1;
            default:               taken = 1'b0;
        endcase
    end

    assign redirect_valid = dec_valid && advance && taken && !dec.illegal;
    assign redirect_pc    = {alu_res[`XLEN-1:1], 1'b0};  // Bit 0 matters only for jalr.

    assign exe_valid   = dec_valid;
    assign exe.pc      = dec.pc;
    assign exe.result  = dec.link ? dec.pc + `XLEN'(4) : alu_res;
    assign exe.rd      = dec.rd;
    assign exe.reg_we  = dec.reg_we && !dec.illegal;
    assign exe.illegal = dec.illegal;

endmodule

/* hw/result_stage.sv */
`include "core_settings.svh"

module result_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  advance,
    input  logic                  exe_valid,
    input  core_bus_pkg::exec_t   exe,
    input  logic [`REG_IDX_W-1:0] rs1_idx,
    input  logic [`REG_IDX_W-1:0] rs2_idx,
    output logic [`XLEN-1:0]      rs1_data,
    output logic [`XLEN-1:0]      rs2_data,
    output logic                  retire_valid,
    output core_bus_pkg::retire_t retire
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    // ==================================================
    // Register file and retire register
    // ==================================================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
            retire_valid <= 1'b0;
            retire       <= '0;
        end else if (advance) begin
            retire_valid <= exe_valid;
            if (exe_valid) begin
                retire <= '{pc: exe.pc, result: exe.result, rd: exe.rd,
                            reg_we: exe.reg_we, illegal: exe.illegal};
                if (exe.reg_we && (exe.rd != '0)) begin
                    regs[exe.rd] <= exe.result;  // x0 is never written.
                end
            end
        end
    end

    assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

endmodule

/* hw/core_top.sv */
`include "core_settings.svh"

module core_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  core_bus_pkg::fetch_t  in_fetch,
    output logic                  in_ready,
    input  logic                  out_ready,
    output logic                  retire_valid,
    output core_bus_pkg::retire_t retire,
    output logic                  redirect_valid,
    output logic [`XLEN-1:0]      redirect_pc
);

    logic                   advance;
    logic                   dec_valid;
    core_bus_pkg::decoded_t dec;
    logic                   exe_valid;
    core_bus_pkg::exec_t    exe;
    logic [`REG_IDX_W-1:0]  rs1_idx;
    logic [`REG_IDX_W-1:0]  rs2_idx;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;

    decode_stage decode_i (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (in_valid),
        .in_fetch       (in_fetch),
        .in_ready       (in_ready),
        .out_ready      (out_ready),
        .advance        (advance),
        .redirect_valid (redirect_valid),
        .exe_valid      (exe_valid),
        .exe            (exe),
        .rs1_idx        (rs1_idx),
        .rs2_idx        (rs2_idx),
        .rs1_data       (rs1_data),
        .rs2_data       (rs2_data),
        .dec_valid      (dec_valid),
        .dec            (dec)
    );

    execute_stage execute_i (
        .dec_valid      (dec_valid),
        .dec            (dec),
        .advance        (advance),
        .exe_valid      (exe_valid),
        .exe            (exe),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    result_stage result_i (
        .clk            (clk),
        .rst            (rst),
        .advance        (advance),
        .exe_valid      (exe_valid),
        .exe            (exe),
        .rs1_idx        (rs1_idx),
        .rs2_idx        (rs2_idx),
        .rs1_data       (rs1_data),
        .rs2_data       (rs2_data),
        .retire_valid   (retire_valid),
        .retire         (retire)
    );

endmodule

/* sim/tb_clock_gen.sv */
module tb_clock_gen (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period.
    end

    initial begin
        rst = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;  // Released just after the tenth rising edge.
    end

endmodule

/* sim/core_tb.sv */
`include "core_settings.svh"

module core_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_RETIRE = 3000;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] inst;
        int               acc_cyc;
    } pending_t;

    logic                  clk;
    logic                  rst;
    logic                  in_valid;
    core_bus_pkg::fetch_t  in_fetch;
    logic                  in_ready;
    logic                  out_ready;
    logic                  retire_valid;
    core_bus_pkg::retire_t retire;
    logic                  redirect_valid;
    logic [`XLEN-1:0]      redirect_pc;

    integer                seed;
    logic [31:0]           stim;
    logic [`XLEN-1:0]      mregs [`REG_COUNT];
    pending_t              pend_q [$];
    logic [`XLEN-1:0]      pc;
    logic [`XLEN-1:0]      cur_inst;
    int                    cyc;
    int                    retired;
    int                    last_stall;
    logic                  started;
    logic                  prev_stall;
    logic                  prev_valid;
    core_bus_pkg::retire_t prev_retire;

    tb_clock_gen clock_i (
        .clk (clk),
        .rst (rst)
    );

    core_top dut_i (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (in_valid),
        .in_fetch       (in_fetch),
        .in_ready       (in_ready),
        .out_ready      (out_ready),
        .retire_valid   (retire_valid),
        .retire         (retire),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] got);
        if (exp !== got) begin
            fail_run($sformatf("mismatch %s exp=%h got=%h", name, exp, got));
        end
    endtask

    // ==================================================
    // Random instruction stream
    // ==================================================

    task automatic gen_inst(output logic [`XLEN-1:0] inst);
        logic [31:0] r;
        logic [31:0] s;
        logic [3:0]  rd;
        logic [3:0]  rs1;
        logic [3:0]  rs2;
        logic [2:0]  f3;
        logic [2:0]  bf3;
        logic [6:0]  f7;
        logic [11:0] imm;
        logic [12:0] off_b;
        logic [20:0] off_j;
        r     = $random(seed);
        s     = $random(seed);
        rd    = {r[7] & r[8], r[6:4]};  // Low registers are favored, so dependencies are common.
        rs1   = {r[12] & r[13], r[11:9]};
        rs2   = {r[17] & r[18], r[16:14]};
        f3    = r[21:19];
        bf3   = (f3[2:1] == 2'b01) ? {1'b1, f3[1:0]} : f3;
        f7    = ((f3 == 3'd0 || f3 == 3'd5) && s[0]) ? 7'h20 : 7'h00;
        off_b = {{7{s[6]}}, s[5:2], 2'b00};
        off_j = {{15{s[6]}}, s[5:2], 2'b00};
        case (f3)
            3'd1:    imm = {7'h00, s[4:0]};
            3'd5:    imm = {f7, s[5:1]};
            default: imm = s[11:0];
        endcase
        case (r[3:0])
            4'd0: begin
                if (s[3]) begin
                    inst = {s[31:7], 7'h03};  // Load opcode, not supported here.
                end else begin
                    inst = {7'h00, s[2], rs2, (s[2:1] == 2'b01), rs1, f3, (s[2:1] == 2'b00),
                            rd, 7'h33};
                end
            end
            4'd1: inst = {off_b[12], off_b[10:5], 1'b0, rs2, 1'b0, rs1, bf3, off_b[4:1],
                          off_b[11], 7'h63};
            4'd2: begin
                if (s[31]) begin
                    inst = {off_j[20], off_j[10:1], off_j[11], off_j[19:12], 1'b0, rd, 7'h6f};
                end else begin
                    inst = {s[18:7], 1'b0, rs1, 3'b000, 1'b0, rd, 7'h67};
                end
            end
            4'd3, 4'd4, 4'd5, 4'd6, 4'd7, 4'd8, 4'd9:
                inst = {f7, 1'b0, rs2, 1'b0, rs1, f3, 1'b0, rd, 7'h33};
            4'd10, 4'd11, 4'd12, 4'd13:
                inst = {imm, 1'b0, rs1, f3, 1'b0, rd, 7'h13};
            4'd14:   inst = {s[19:0], 1'b0, rd, 7'h37};
            default: inst = {s[19:0], 1'b0, rd, 7'h17};
        endcase
    endtask

    // ==================================================
    // Reference ISA model
    // ==================================================

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] x, input logic [31:0] y);
        case (f3)
            3'd0: return alt ? x - y : x + y;
            3'd1: return x << y[4:0];
            3'd2: return {31'b0, $signed(x) < $signed(y)};
            3'd3: return {31'b0, x < y};
            3'd4: return x ^ y;
            3'd5: begin
                if (alt) begin
                    return $signed(x) >>> y[4:0];
                end
                return x >> y[4:0];
            end
            3'd6: return x | y;
            default: return x & y;
        endcase
    endfunction

    function automatic void eval_inst(input logic [31:0] ipc, input logic [31:0] inst,
                                      output core_bus_pkg::retire_t want,
                                      output logic taken, output logic [31:0] target);
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [31:0] imm_u;
        logic        legal;
        logic        use1;
        logic        use2;
        logic        usew;
        rd    = inst[11:7];
        rs1   = inst[19:15];
        rs2   = inst[24:20];
        f3    = inst[14:12];
        f7    = inst[31:25];
        a     = mregs[rs1[3:0]];  // Register 0 is never written, so it reads zero.
        b     = mregs[rs2[3:0]];
        imm_i = {{20{inst[31]}}, inst[31:20]};
        imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        imm_u = {inst[31:12], 12'b0};
        want    = '0;
        want.pc = ipc;
        want.rd = rd[3:0];
        taken   = 1'b0;
        target  = '0;
        legal   = 1'b1;
        use1    = 1'b0;
        use2    = 1'b0;
        usew    = 1'b1;
        case (inst[6:0])
            7'h33: begin
                use1        = 1'b1;
                use2        = 1'b1;
                legal       = (f7 == 7'h00) || ((f7 == 7'h20) && (f3 == 3'd0 || f3 == 3'd5));
                want.result = alu_ref(f3, f7[5], a, b);
            end
            7'h13: begin
                use1 = 1'b1;
                if (f3 == 3'd1) legal = (f7 == 7'h00);
                if (f3 == 3'd5) legal = (f7 == 7'h00) || (f7 == 7'h20);
                want.result = alu_ref(f3, (f3 == 3'd5) && f7[5], a, imm_i);
            end
            7'h37: want.result = imm_u;
            7'h17: want.result = ipc + imm_u;
            7'h6f: begin
                want.result = ipc + 32'd4;
                taken       = 1'b1;
                target      = ipc + imm_j;
            end
            7'h67: begin
                use1        = 1'b1;
                legal       = (f3 == 3'd0);
                want.result = ipc + 32'd4;
                taken       = 1'b1;
                target      = (a + imm_i) & ~32'h1;
            end
            7'h63: begin
                use1   = 1'b1;
                use2   = 1'b1;
                usew   = 1'b0;
                target = ipc + imm_b;
                case (f3)
                    3'd0:    taken = (a == b);
                    3'd1:    taken = (a != b);
                    3'd4:    taken = ($signed(a) < $signed(b));
                    3'd5:    taken = ($signed(a) >= $signed(b));
                    3'd6:    taken = (a < b);
                    3'd7:    taken = (a >= b);
                    default: legal = 1'b0;
                endcase
            end
            default: legal = 1'b0;
        endcase
        if ((use1 && rs1[4]) || (use2 && rs2[4]) || (usew && rd[4])) legal = 1'b0;
        want.reg_we  = legal && usew;
        want.illegal = !legal;
        taken        = taken && legal;
    endfunction

    // ==================================================
    // Per-cycle checks, sampled 1 ns before the edge
    // ==================================================

    task automatic check_cycle();
        pending_t              ent;
        core_bus_pkg::retire_t want;
        logic                  taken;
        logic [`XLEN-1:0]      target;
        logic                  accepted;
        check_eq("in_ready", 32'(out_ready), 32'(in_ready));
        if (!started) begin
            check_eq("retire_valid", 32'd0, 32'(retire_valid));
            check_eq("redirect_valid", 32'd0, 32'(redirect_valid));
        end
        if (prev_stall) begin
            check_eq("retire_valid", 32'(prev_valid), 32'(retire_valid));
            check_eq("retire.pc", prev_retire.pc, retire.pc);
            check_eq("retire.result", prev_retire.result, retire.result);
            check_eq("retire.flags",
                     32'({prev_retire.rd, prev_retire.reg_we, prev_retire.illegal}),
                     32'({retire.rd, retire.reg_we, retire.illegal}));
        end
        if (out_ready) begin
            if (retire_valid) begin
                if (pend_q.size() == 0) fail_run("retire_valid high with no instruction in flight");
                ent = pend_q.pop_front();
                eval_inst(ent.pc, ent.inst, want, taken, target);
                check_eq("retire.pc", want.pc, retire.pc);
                check_eq("retire.illegal", 32'(want.illegal), 32'(retire.illegal));
                check_eq("retire.reg_we", 32'(want.reg_we), 32'(retire.reg_we));
                if (want.reg_we) begin
                    check_eq("retire.rd", 32'(want.rd), 32'(retire.rd));
                    check_eq("retire.result", want.result, retire.result);
                    if (want.rd != '0) mregs[want.rd] = want.result;
                end
                if (ent.acc_cyc > last_stall) begin
                    check_eq("retire latency", 32'(ent.acc_cyc + 2), 32'(cyc));
                end
                retired++;
            end
            if (pend_q.size() > 1) fail_run("an instruction was lost between decode and retire");
            taken  = 1'b0;
            target = '0;
            if (pend_q.size() > 0) eval_inst(pend_q[0].pc, pend_q[0].inst, want, taken, target);
            check_eq("redirect_valid", 32'(taken), 32'(redirect_valid));
            if (taken) check_eq("redirect_pc", target, redirect_pc);
        end else begin
            check_eq("redirect_valid", 32'd0, 32'(redirect_valid));
            last_stall = cyc;
        end
        accepted = in_valid && in_ready;
        if (accepted && !redirect_valid) begin  // A fetch taken during a redirect is dropped.
            ent.pc      = pc;
            ent.inst    = cur_inst;
            ent.acc_cyc = cyc;
            pend_q.push_back(ent);
        end
        if (accepted) started = 1'b1;
        if (redirect_valid) begin
            pc = redirect_pc;
            gen_inst(cur_inst);
        end else if (accepted) begin
            pc = pc + 32'd4;
            gen_inst(cur_inst);
        end
        prev_stall  = !out_ready;
        prev_valid  = retire_valid;
        prev_retire = retire;
    endtask

    initial begin
        #(N_RETIRE * 40 * 4);  // Allows 40 cycles per retirement.
        fail_run("watchdog expired before all instructions retired");
    end

    initial begin
        seed        = 32'h8ff7;
        in_valid    = 1'b0;
        out_ready   = 1'b0;
        in_fetch    = '0;
        cyc         = 0;
        retired     = 0;
        last_stall  = -1;
        started     = 1'b0;
        prev_stall  = 1'b0;
        prev_valid  = 1'b0;
        prev_retire = '0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            mregs[i] = '0;
        end
        pc = '0;
        gen_inst(cur_inst);
        @(negedge rst);
        while (retired < N_RETIRE) begin
            @(posedge clk);
            #1;
            stim          = $random(seed);
            in_valid      = (stim[1:0] != 2'b00);
            out_ready     = (stim[3:2] != 2'b00);
            in_fetch.pc   = pc;
            in_fetch.inst = cur_inst;
            #2;
            check_cycle();
            cyc++;
        end
        $display("** PASS **");
        $finish;
    end

endmodule

/* sim.f */
+incdir+hw
hw/rv_isa_pkg.sv
hw/core_bus_pkg.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/result_stage.sv
hw/core_top.sv
sim/tb_clock_gen.sv
sim/core_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary -j 0 --timescale 1ns/100ps
TOP       = core_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
